/* dostring_pkg.sv */
package dostring_pkg;

  // Frame geometry and sine table size
  localparam int STRING_SIZE = 47;
  localparam int SINE_STEPS = 47;

  // Builder idle cycles before a frame and offset of the band split point
  localparam int COLOR_DELAY = 5;
  localparam int MIDDLE_OFFSET = 5;

  typedef logic [7:0] color_t;
  typedef logic [5:0] phase_t;
  typedef logic [5:0] pixel_idx_t;

  typedef struct packed {
    color_t blue;
    color_t green;
    color_t red;
  } pixel_t;

  typedef struct packed {
    phase_t blue;
    phase_t green;
    phase_t red;
  } band_phase_t;

  // Phases of each band right after reset
  localparam band_phase_t TOP_START = '{blue: 6'd10, green: 6'd0, red: 6'd20};
  localparam band_phase_t MIDDLE_START = '{blue: 6'd3, green: 6'd30, red: 6'd23};
  localparam band_phase_t BOTTOM_START = '{blue: 6'd30, green: 6'd40, red: 6'd0};

  // Phase increments applied once per frame
  localparam band_phase_t TOP_STEP = '{blue: 6'd3, green: 6'd2, red: 6'd1};
  localparam band_phase_t MIDDLE_STEP = '{blue: 6'd2, green: 6'd1, red: 6'd3};
  localparam band_phase_t BOTTOM_STEP = '{blue: 6'd1, green: 6'd2, red: 6'd2};

  typedef enum logic [1:0] {
    REC_START = 2'd0,
    REC_PIXEL = 2'd1,
    REC_END = 2'd2
  } record_kind_e;

  // The pixel field carries zero on start and end records
  typedef struct packed {
    record_kind_e kind;
    pixel_t pixel;
  } strip_record_t;

endpackage

/* sine_table.sv */
`timescale 1ns/10ps

module sine_table (
  input  dostring_pkg::band_phase_t color_phase,
  output dostring_pkg::pixel_t      color_value,
  input  dostring_pkg::phase_t      split_phase,
  output dostring_pkg::color_t      split_value
);
  import dostring_pkg::*;

  // One full period of a sine wave between 0 and 99
  function automatic color_t sine_at(input phase_t idx);
    color_t value;
    case (idx)
      6'd0: value = 8'd50;
      6'd1: value = 8'd56;
      6'd2: value = 8'd62;
      6'd3: value = 8'd68;
      6'd4: value = 8'd75;
      6'd5: value = 8'd80;
      6'd6: value = 8'd85;
      6'd7: value = 8'd89;
      6'd8: value = 8'd93;
      6'd9: value = 8'd96;
      6'd10: value = 8'd98;
      6'd11: value = 8'd99;
      6'd12: value = 8'd99;
      6'd13: value = 8'd99;
      6'd14: value = 8'd97;
      6'd15: value = 8'd95;
      6'd16: value = 8'd92;
      6'd17: value = 8'd88;
      6'd18: value = 8'd84;
      6'd19: value = 8'd78;
      6'd20: value = 8'd72;
      6'd21: value = 8'd67;
      6'd22: value = 8'd60;
      6'd23: value = 8'd53;
      6'd24: value = 8'd47;
      6'd25: value = 8'd40;
      6'd26: value = 8'd33;
      6'd27: value = 8'd28;
      6'd28: value = 8'd22;
      6'd29: value = 8'd16;
      6'd30: value = 8'd12;
      6'd31: value = 8'd8;
      6'd32: value = 8'd4;
      6'd33: value = 8'd2;
      6'd34: value = 8'd0;
      6'd35: value = 8'd0;
      6'd36: value = 8'd0;
      6'd37: value = 8'd1;
      6'd38: value = 8'd3;
      6'd39: value = 8'd5;
      6'd40: value = 8'd9;
      6'd41: value = 8'd14;
      6'd42: value = 8'd18;
      6'd43: value = 8'd24;
      6'd44: value = 8'd30;
      6'd45: value = 8'd36;
      6'd46: value = 8'd43;
      default: value = 8'd0;
    endcase
    return value;
  endfunction

  assign color_value.blue = sine_at(color_phase.blue);
  assign color_value.green = sine_at(color_phase.green);
  assign color_value.red = sine_at(color_phase.red);
  assign split_value = sine_at(split_phase);

  // Every lookup must land inside the table once the inputs are known
  always_comb
  begin
    if (!$isunknown({color_phase, split_phase}))
    begin
      assert final (color_phase.blue < SINE_STEPS && color_phase.green < SINE_STEPS &&
                    color_phase.red < SINE_STEPS && split_phase < SINE_STEPS)
        else $error("sine_table: phase outside the table");
    end
  end

endmodule

/* wave_band_phases.sv */
`timescale 1ns/10ps

module wave_band_phases (
  input  logic                      dostring_clk,
  input  logic                      reset,
  input  logic                      advance,
  output dostring_pkg::band_phase_t top,
  output dostring_pkg::band_phase_t middle,
  output dostring_pkg::band_phase_t bottom
);
  import dostring_pkg::*;

  // Adds a step and wraps back into the table range
  function automatic phase_t step_phase(input phase_t phase, input phase_t step);
    phase_t sum;
    sum = phase + step;
    if (sum >= phase_t'(SINE_STEPS))
      sum = sum - phase_t'(SINE_STEPS);
    return sum;
  endfunction

  function automatic band_phase_t step_band(input band_phase_t band, input band_phase_t step);
    band_phase_t next;
    next.blue = step_phase(band.blue, step.blue);
    next.green = step_phase(band.green, step.green);
    next.red = step_phase(band.red, step.red);
    return next;
  endfunction

  always_ff @(posedge dostring_clk)
  begin
    if (reset)
    begin
      top <= TOP_START;
      middle <= MIDDLE_START;
      bottom <= BOTTOM_START;
    end
    else if (advance)
    begin
      top <= step_band(top, TOP_STEP);
      middle <= step_band(middle, MIDDLE_STEP);
      bottom <= step_band(bottom, BOTTOM_STEP);
    end
  end

  assert property (@(posedge dostring_clk) disable iff (reset)
    top.blue < SINE_STEPS && top.green < SINE_STEPS && top.red < SINE_STEPS &&
    middle.blue < SINE_STEPS && middle.green < SINE_STEPS && middle.red < SINE_STEPS &&
    bottom.blue < SINE_STEPS && bottom.green < SINE_STEPS && bottom.red < SINE_STEPS)
    else $error("wave_band_phases: phase left the table range");

endmodule

/* wave_frame_builder.sv */
`timescale 1ns/10ps

module wave_frame_builder (
  input  logic                     dostring_clk,
  input  logic                     reset,
  input  logic                     working_free,
  output logic                     frame_ready,
  output logic                     wr_en,
  output dostring_pkg::pixel_idx_t wr_idx,
  output dostring_pkg::pixel_t     wr_pixel
);
  import dostring_pkg::*;

  typedef enum logic [2:0] {
    B_IDLE,
    B_DELAY,
    B_SELECT,
    B_WRITE,
    B_READY
  } build_state_e;

  build_state_e state;
  logic [2:0] delay_cnt;
  logic advance;
  phase_t frame_idx;
  phase_t split_phase;
  color_t split_value;
  pixel_idx_t split;
  pixel_idx_t pixel_idx;
  band_phase_t sel_phase;
  band_phase_t top;
  band_phase_t middle;
  band_phase_t bottom;

  assign frame_ready = (state == B_READY);
  assign wr_en = (state == B_WRITE);
  assign wr_idx = pixel_idx;
  // Phases move on once the buffer has taken the frame
  assign advance = (state == B_READY) && !working_free;

  // The split point follows the sine value of the previous frame index
  assign split_phase = (frame_idx == '0) ? phase_t'(SINE_STEPS - 1) : frame_idx - 6'd1;

  wave_band_phases i_band_phases (
    .dostring_clk (dostring_clk),
    .reset        (reset),
    .advance      (advance),
    .top          (top),
    .middle       (middle),
    .bottom       (bottom)
  );

  sine_table i_sine_table (
    .color_phase (sel_phase),
    .color_value (wr_pixel),
    .split_phase (split_phase),
    .split_value (split_value)
  );

  always_ff @(posedge dostring_clk)
  begin
    if (reset)
    begin
      state <= B_IDLE;
      delay_cnt <= '0;
      pixel_idx <= '0;
      frame_idx <= '0;
    end
    else
    begin
      case (state)
        B_IDLE:
          if (working_free)
          begin
            delay_cnt <= '0;
            pixel_idx <= '0;
            state <= B_DELAY;
          end
        B_DELAY:
          if (delay_cnt == 3'(COLOR_DELAY))
            state <= B_SELECT;
          else
            delay_cnt <= delay_cnt + 3'd1;
        B_SELECT:
          state <= B_WRITE;
        B_WRITE:
          if (pixel_idx == pixel_idx_t'(STRING_SIZE - 1))
            state <= B_READY;
          else
          begin
            pixel_idx <= pixel_idx + 6'd1;
            state <= B_SELECT;
          end
        B_READY:
          if (!working_free)
          begin
            frame_idx <= (frame_idx == phase_t'(SINE_STEPS - 1)) ? '0 : frame_idx + 6'd1;
            state <= B_IDLE;
          end
        default:
          state <= B_IDLE;
      endcase
    end
  end

  always_ff @(posedge dostring_clk)
  begin
    if (state == B_IDLE && working_free)
      split <= pixel_idx_t'(split_value / 8'd3) + pixel_idx_t'(MIDDLE_OFFSET);
    // Top band above the split, middle band on it, bottom band below
    if (state == B_SELECT)
    begin
      if (pixel_idx < split)
        sel_phase <= top;
      else if (pixel_idx == split)
        sel_phase <= middle;
      else
        sel_phase <= bottom;
    end
  end

endmodule

/* frame_double_buffer.sv */
`timescale 1ns/10ps

module frame_double_buffer (
  input  logic                     dostring_clk,
  input  logic                     reset,
  input  logic                     wr_en,
  input  dostring_pkg::pixel_idx_t wr_idx,
  input  dostring_pkg::pixel_t     wr_pixel,
  input  logic                     frame_ready,
  output logic                     working_free,
  input  dostring_pkg::pixel_idx_t rd_idx,
  output dostring_pkg::pixel_t     rd_pixel,
  input  logic                     sending,
  output logic                     current_ready
);
  import dostring_pkg::*;

  typedef enum logic [1:0] {
    M_IDLE,
    M_COPY,
    M_HAND
  } move_state_e;

  move_state_e state;
  pixel_idx_t move_idx;
  pixel_t working_store [STRING_SIZE];
  pixel_t current_store [STRING_SIZE];

  assign rd_pixel = current_store[rd_idx];

  always_ff @(posedge dostring_clk)
  begin
    if (wr_en)
      working_store[wr_idx] <= wr_pixel;
    if (state == M_COPY)
      current_store[move_idx] <= working_store[move_idx];
  end

  always_ff @(posedge dostring_clk)
  begin
    if (reset)
    begin
      state <= M_IDLE;
      move_idx <= '0;
      working_free <= 1'b1;
      current_ready <= 1'b0;
    end
    else
    begin
      // The sender has picked up the current frame
      if (sending)
        current_ready <= 1'b0;
      case (state)
        M_IDLE:
          // Copy only when the current store is neither pending nor on its way out
          if (frame_ready && !current_ready && !sending)
          begin
            working_free <= 1'b0;
            move_idx <= '0;
            state <= M_COPY;
          end
        M_COPY:
          if (move_idx == pixel_idx_t'(STRING_SIZE - 1))
            state <= M_HAND;
          else
            move_idx <= move_idx + 6'd1;
        M_HAND:
        begin
          current_ready <= 1'b1;
          working_free <= 1'b1;
          state <= M_IDLE;
        end
        default:
          state <= M_IDLE;
      endcase
    end
  end

  // The builder must leave the working store alone while a copy is running
  assert property (@(posedge dostring_clk) disable iff (reset) wr_en |-> working_free)
    else $error("frame_double_buffer: write into the working store while it is taken");

endmodule

/* strip_frame_sender.sv */
`timescale 1ns/10ps

module strip_frame_sender (
  input  logic                        dostring_clk,
  input  logic                        reset,
  input  logic                        current_ready,
  output logic                        sending,
  output dostring_pkg::pixel_idx_t    rd_idx,
  input  dostring_pkg::pixel_t        rd_pixel,
  output dostring_pkg::strip_record_t strip_record,
  output logic                        strip_start,
  input  logic                        strip_busy
);
  import dostring_pkg::*;

  typedef enum logic [2:0] {
    S_IDLE,
    S_WAIT_FREE,
    S_LOAD,
    S_FIRE,
    S_WAIT_ACK,
    S_DONE
  } send_state_e;

  send_state_e state;
  record_kind_e next_kind;

  always_ff @(posedge dostring_clk)
  begin
    if (reset)
    begin
      state <= S_IDLE;
      next_kind <= REC_START;
      rd_idx <= '0;
      sending <= 1'b0;
      strip_start <= 1'b0;
      strip_record <= '0;
    end
    else
    begin
      case (state)
        S_IDLE:
          if (current_ready)
          begin
            sending <= 1'b1;
            next_kind <= REC_START;
            rd_idx <= '0;
            state <= S_WAIT_FREE;
          end
        S_WAIT_FREE:
          if (!strip_busy)
            state <= S_LOAD;
        S_LOAD:
        begin
          strip_record.kind <= next_kind;
          strip_record.pixel <= (next_kind == REC_PIXEL) ? rd_pixel : pixel_t'('0);
          state <= S_FIRE;
        end
        S_FIRE:
        begin
          strip_start <= 1'b1;
          state <= S_WAIT_ACK;
        end
        S_WAIT_ACK:
          // The shifter has taken the record, so pick the one that follows
          if (strip_busy)
          begin
            strip_start <= 1'b0;
            state <= S_WAIT_FREE;
            case (next_kind)
              REC_START:
                next_kind <= REC_PIXEL;
              REC_PIXEL:
                if (rd_idx == pixel_idx_t'(STRING_SIZE - 1))
                  next_kind <= REC_END;
                else
                  rd_idx <= rd_idx + 6'd1;
              default:
                state <= S_DONE;
            endcase
          end
        S_DONE:
          if (!strip_busy)
          begin
            sending <= 1'b0;
            state <= S_IDLE;
          end
        default:
          state <= S_IDLE;
      endcase
    end
  end

  assert property (@(posedge dostring_clk) disable iff (reset)
    strip_start && $past(strip_start) |-> $stable(strip_record))
    else $error("strip_frame_sender: record changed while offered");

endmodule

/* dostring_wave.sv */
`timescale 1ns/10ps

module dostring_wave (
  input  logic                        dostring_clk,
  input  logic                        reset,
  output dostring_pkg::strip_record_t strip_record,
  output logic                        strip_start,
  input  logic                        strip_busy
);
  import dostring_pkg::*;

  logic working_free;
  logic frame_ready;
  logic wr_en;
  pixel_idx_t wr_idx;
  pixel_t wr_pixel;
  logic current_ready;
  logic sending;
  pixel_idx_t rd_idx;
  pixel_t rd_pixel;

  wave_frame_builder i_frame_builder (
    .dostring_clk (dostring_clk),
    .reset        (reset),
    .working_free (working_free),
    .frame_ready  (frame_ready),
    .wr_en        (wr_en),
    .wr_idx       (wr_idx),
    .wr_pixel     (wr_pixel)
  );

  frame_double_buffer i_double_buffer (
    .dostring_clk  (dostring_clk),
    .reset         (reset),
    .wr_en         (wr_en),
    .wr_idx        (wr_idx),
    .wr_pixel      (wr_pixel),
    .frame_ready   (frame_ready),
    .working_free  (working_free),
    .rd_idx        (rd_idx),
    .rd_pixel      (rd_pixel),
    .sending       (sending),
    .current_ready (current_ready)
  );

  strip_frame_sender i_frame_sender (
    .dostring_clk  (dostring_clk),
    .reset         (reset),
    .current_ready (current_ready),
    .sending       (sending),
    .rd_idx        (rd_idx),
    .rd_pixel      (rd_pixel),
    .strip_record  (strip_record),
    .strip_start   (strip_start),
    .strip_busy    (strip_busy)
  );

endmodule

/* tb_dostring_checks.svh */
`ifndef TB_DOSTRING_CHECKS_SVH
`define TB_DOSTRING_CHECKS_SVH

// Sine values of the strip pattern, one per table phase
int sine_ref [SINE_STEPS] = '{
  50, 56, 62, 68, 75, 80, 85, 89, 93, 96,
  98, 99, 99, 99, 97, 95, 92, 88, 84, 78,
  72, 67, 60, 53, 47, 40, 33, 28, 22, 16,
  12, 8, 4, 2, 0, 0, 0, 1, 3, 5,
  9, 14, 18, 24, 30, 36, 43
};

// Rows are top, middle, bottom and columns are blue, green, red
int start_ref [3][3] = '{'{10, 0, 20}, '{3, 30, 23}, '{30, 40, 0}};
int step_ref [3][3] = '{'{3, 2, 1}, '{2, 1, 3}, '{1, 2, 2}};

function automatic int model_phase(input int frame, input int band, input int colour);
  return (start_ref[band][colour] + frame * step_ref[band][colour]) % SINE_STEPS;
endfunction

function automatic pixel_t expected_pixel(input int frame, input int p);
  int split;
  int band;
  pixel_t px;
  // Split point comes from the sine value one frame index back
  split = sine_ref[(frame + SINE_STEPS - 1) % SINE_STEPS] / 3 + MIDDLE_OFFSET;
  if (p < split)
    band = 0;
  else if (p == split)
    band = 1;
  else
    band = 2;
  px.blue = color_t'(sine_ref[model_phase(frame, band, 0)]);
  px.green = color_t'(sine_ref[model_phase(frame, band, 1)]);
  px.red = color_t'(sine_ref[model_phase(frame, band, 2)]);
  return px;
endfunction

task automatic compare_record(input strip_record_t actual, input strip_record_t expected,
                              input string name);
  check_count++;
  if (actual !== expected)
  begin
    $display("FAILED at %0t ns: %s is %h, expected %h", $time, name, actual, expected);
    error_count++;
  end
endtask

task automatic compare_pixel(input pixel_t actual, input pixel_t expected, input string name);
  check_count++;
  if (actual !== expected)
  begin
    $display("FAILED at %0t ns: %s is %h, expected %h", $time, name, actual, expected);
    error_count++;
  end
endtask

task automatic compare_kind(input record_kind_e actual, input record_kind_e expected,
                            input string name);
  check_count++;
  if (actual !== expected)
  begin
    $display("FAILED at %0t ns: %s is %0d, expected %0d", $time, name, actual, expected);
    error_count++;
  end
endtask

task automatic compare_flag(input logic actual, input logic expected, input string name);
  check_count++;
  if (actual !== expected)
  begin
    $display("FAILED at %0t ns: %s is %b, expected %b", $time, name, actual, expected);
    error_count++;
  end
endtask

`endif

/* tb_dostring_wave.sv */
`timescale 1ns/10ps

module tb_dostring_wave;
  import dostring_pkg::*;

  localparam int TIMEOUT_CYCLES = 60 * (STRING_SIZE + 2) * 12;

  logic dostring_clk;
  logic reset;
  strip_record_t strip_record;
  logic strip_start;
  logic strip_busy;

  int error_count = 0;
  int check_count = 0;
  int cycle_count = 0;

  // Shifter model controls and what it has accepted so far
  int fixed_busy = 2;
  logic random_busy = 1'b0;
  int hold_cycles = 0;
  logic hold_active = 1'b0;
  strip_record_t held_record;
  int busy_len;
  integer seed = 16468;
  strip_record_t record_q [$];

  `include "tb_dostring_checks.svh"

  dostring_wave i_dostring_wave (
    .dostring_clk (dostring_clk),
    .reset        (reset),
    .strip_record (strip_record),
    .strip_start  (strip_start),
    .strip_busy   (strip_busy)
  );

  initial
  begin
    dostring_clk = 1'b0;
    forever
      #5 dostring_clk = ~dostring_clk;
  end

  // Pixel shifter: takes a record, answers busy one cycle later and holds it a while
  initial
  begin
    strip_busy = 1'b0;
    forever
    begin
      @(posedge dostring_clk);
      #1;
      if (!reset && strip_start && !strip_busy)
      begin
        record_q.push_back(strip_record);
        strip_busy = 1'b1;
        if (hold_cycles > 0)
        begin
          held_record = strip_record;
          hold_active = 1'b1;
          busy_len = hold_cycles;
          hold_cycles = 0;
        end
        else if (random_busy)
          busy_len = 1 + (($random(seed) & 32'h7fff_ffff) % 8);
        else
          busy_len = fixed_busy;
        repeat (busy_len)
          @(posedge dostring_clk);
        #1;
        strip_busy = 1'b0;
        hold_active = 1'b0;
      end
    end
  end

  initial
  begin
    while (cycle_count < TIMEOUT_CYCLES)
    begin
      @(posedge dostring_clk);
      cycle_count++;
    end
    $display("Timeout: the record stream did not finish within %0d cycles", TIMEOUT_CYCLES);
    $display("Test FAILED");
    $finish;
  end

  function automatic strip_record_t make_record(input record_kind_e kind, input pixel_t pixel);
    strip_record_t rec;
    rec.kind = kind;
    rec.pixel = pixel;
    return rec;
  endfunction

  task automatic next_record(output strip_record_t rec);
    while (record_q.size() == 0)
      @(posedge dostring_clk);
    rec = record_q.pop_front();
  endtask

  task automatic report_test(input string name, input int errors_before);
    $display("%s: %0d errors", name, error_count - errors_before);
  endtask

  task automatic receive_frame(input int frame);
    strip_record_t rec;
    int p;
    next_record(rec);
    compare_record(rec, make_record(REC_START, '0),
                   $sformatf("frame %0d start strip_record", frame));
    for (p = 0; p < STRING_SIZE; p++)
    begin
      next_record(rec);
      compare_kind(rec.kind, REC_PIXEL,
                   $sformatf("frame %0d strip_record.kind[%0d]", frame, p));
      compare_pixel(rec.pixel, expected_pixel(frame, p),
                    $sformatf("frame %0d strip_record.pixel[%0d]", frame, p));
    end
    next_record(rec);
    compare_record(rec, make_record(REC_END, '0),
                   $sformatf("frame %0d end strip_record", frame));
  endtask

  task automatic reset_stays_quiet();
    int errors_before;
    errors_before = error_count;
    reset = 1'b1;
    repeat (16)
    begin
      @(posedge dostring_clk);
      #1;
      compare_flag(strip_start, 1'b0, "strip_start during reset");
    end
    reset = 1'b0;
    // The very first offer has to be a start record
    while (record_q.size() == 0)
      @(posedge dostring_clk);
    compare_record(record_q[0], make_record(REC_START, '0), "first strip_record");
    report_test("reset and first offer", errors_before);
  endtask

  task automatic first_frame_matches();
    int errors_before;
    errors_before = error_count;
    receive_frame(0);
    report_test("first frame", errors_before);
  endtask

  task automatic frames_under_random_busy();
    int errors_before;
    int frame;
    errors_before = error_count;
    random_busy = 1'b1;
    for (frame = 1; frame <= 5; frame++)
      receive_frame(frame);
    random_busy = 1'b0;
    report_test("frames 1 to 5 with random busy", errors_before);
  endtask

  task automatic watch_busy_hold();
    strip_record_t held;
    while (!hold_active)
    begin
      @(posedge dostring_clk);
      #2;
    end
    held = held_record;
    @(posedge dostring_clk);
    #2;
    while (hold_active)
    begin
      compare_flag(strip_start, 1'b0, "strip_start during hold");
      compare_record(strip_record, held, "strip_record during hold");
      @(posedge dostring_clk);
      #2;
    end
  endtask

  task automatic long_busy_stall();
    int errors_before;
    errors_before = error_count;
    fixed_busy = 2;
    hold_cycles = 200;
    fork
      watch_busy_hold();
      receive_frame(6);
    join
    report_test("busy held for 200 cycles", errors_before);
  endtask

  task automatic wrap_through_frame_48();
    int errors_before;
    int frame;
    errors_before = error_count;
    fixed_busy = 1;
    for (frame = 7; frame <= 48; frame++)
      receive_frame(frame);
    report_test("frames 7 to 48 with index wrap", errors_before);
  endtask

  initial
  begin
    reset = 1'b1;
    reset_stays_quiet();
    first_frame_matches();
    frames_under_random_busy();
    long_busy_stall();
    wrap_through_frame_48();
    $display("%0d checks run, %0d errors", check_count, error_count);
    if (error_count == 0)
      $display("Test OK");
    else
      $display("Test FAILED");
    $finish;
  end

endmodule

/* flist.f */
+incdir+.
dostring_pkg.sv
sine_table.sv
wave_band_phases.sv
wave_frame_builder.sv
frame_double_buffer.sv
strip_frame_sender.sv
dostring_wave.sv
tb_dostring_wave.sv

/* Bender.yml */
package:
  name: dostring_wave

sources:
  - dostring_pkg.sv
  - sine_table.sv
  - wave_band_phases.sv
  - wave_frame_builder.sv
  - frame_double_buffer.sv
  - strip_frame_sender.sv
  - dostring_wave.sv
  - target: simulation
    include_dirs:
      - .
    files:
      - tb_dostring_wave.sv
